//--- lv_hv_shadow.f
logic/owt_pkg.sv
logic/shadow_pkg.sv
logic/owt_frame_capture.sv
logic/shadow_reg_bank.sv
logic/hv_reg_forward.sv
logic/lv_hv_shadow.sv
test/lv_hv_shadow_tb.sv

//--- test/lv_hv_shadow_tb.sv
/*
 * Testbench for the low-voltage shadow top level.
 * Drives directed and random one-wire frames on the falling edge and checks
 * o_regs and both forward pulses against a two-stage reference model.
 */
`timescale 1ns/10ps

module lv_hv_shadow_tb;

    localparam int CLK_PERIOD  = 10;
    localparam int N_DIRECTED  = 9;
    localparam int N_RANDOM    = 400;
    localparam int WATCHDOG_NS = (N_DIRECTED + N_RANDOM + 50) * CLK_PERIOD;

    // one snapshot of everything the DUT shows
    typedef struct packed {
        shadow_pkg::shadow_regs_t   regs;
        logic                       ang_vld;
        logic [owt_pkg::REG_DW-1:0] ang_data;
        logic                       dgt_vld;
    } expect_t;

    logic                           clk;
    logic                           rst_n;
    logic                           rx_ack;
    owt_pkg::owt_cmd_t              rx_cmd;
    logic [owt_pkg::OWT_DATA_W-1:0] rx_data;
    logic                           rx_status;

    shadow_pkg::shadow_regs_t       regs;
    logic                           ang_vld;
    logic [owt_pkg::REG_DW-1:0]     ang_data;
    logic                           dgt_vld;

    shadow_pkg::shadow_regs_t       model_regs;
    logic [owt_pkg::REG_DW-1:0]     model_ang_data;
    expect_t                        expect_q[$];
    int                             error_count;
    int                             check_count;

    logic [owt_pkg::REG_AW-1:0] mapped_addrs [9] = '{
        shadow_pkg::ADDR_EFUSE_CFG, shadow_pkg::ADDR_EFUSE_STS,
        shadow_pkg::ADDR_STATUS1, shadow_pkg::ADDR_STATUS2,
        shadow_pkg::ADDR_STATUS3, shadow_pkg::ADDR_STATUS4,
        shadow_pkg::ADDR_BIST1, shadow_pkg::ADDR_BIST2,
        shadow_pkg::ADDR_ADC
    };

    logic [owt_pkg::REG_AW-1:0] dgt_addrs [4] = '{7'h40, 7'h41, 7'h48, 7'h50};

    lv_hv_shadow i_lv_hv_shadow (
        .i_clk             (clk),
        .i_rst_n           (rst_n),
        .i_owt_rx_ack      (rx_ack),
        .i_owt_rx_cmd      (rx_cmd),
        .i_owt_rx_data     (rx_data),
        .i_owt_rx_status   (rx_status),
        .o_regs            (regs),
        .o_hv_ang_reg_vld  (ang_vld),
        .o_hv_ang_reg_data (ang_data),
        .o_hv_dgt_reg_vld  (dgt_vld)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish in %0d ns", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    // ========================================
    // reference model
    // ========================================
    function automatic logic in_analog_range(input logic [owt_pkg::REG_AW-1:0] addr);
        return (addr >= 7'h20) && (addr <= 7'h3F);
    endfunction

    function automatic logic in_digital_list(input logic [owt_pkg::REG_AW-1:0] addr);
        logic hit;
        hit = 1'b0;
        foreach (dgt_addrs[i]) begin
            if (addr == dgt_addrs[i]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // state seen two edges after these inputs are sampled
    task automatic apply_model(input logic ack, input owt_pkg::owt_cmd_t cmd,
                               input logic [owt_pkg::OWT_DATA_W-1:0] data,
                               input logic status);
        expect_t e;
        logic    accept;
        accept    = ack && !status;
        e.ang_vld = accept && in_analog_range(cmd.addr);
        e.dgt_vld = accept && in_digital_list(cmd.addr);
        if (e.ang_vld) begin
            model_ang_data = data[7:0];
        end
        if (accept && cmd.wr) begin
            case (cmd.addr)
                7'h06: model_regs.efuse_cfg = data[7:0];
                7'h07: model_regs.efuse_sts = data[7:0];
                7'h08: model_regs.status1   = data[7:0];
                7'h0A: model_regs.status2   = data[7:0];
                7'h0C: model_regs.status3   = data[7:0];
                7'h0D: model_regs.status4   = data[7:0];
                7'h14: model_regs.bist1     = data[7:0];
                7'h15: model_regs.bist2     = data[7:0];
                7'h1F: begin
                    model_regs.adc1 = data[9:0];
                    model_regs.adc2 = data[19:10];
                end
                default: begin
                end
            endcase
        end
        e.regs     = model_regs;
        e.ang_data = model_ang_data;
        expect_q.push_back(e);
    endtask

    // ========================================
    // checking
    // ========================================
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h at %0t ns",
                     name, got, exp, $time);
        end
    endtask

    task automatic compare_outputs(input expect_t e);
        check_value("o_regs.efuse_cfg", regs.efuse_cfg, e.regs.efuse_cfg);
        check_value("o_regs.efuse_sts", regs.efuse_sts, e.regs.efuse_sts);
        check_value("o_regs.status1", regs.status1, e.regs.status1);
        check_value("o_regs.status2", regs.status2, e.regs.status2);
        check_value("o_regs.status3", regs.status3, e.regs.status3);
        check_value("o_regs.status4", regs.status4, e.regs.status4);
        check_value("o_regs.bist1", regs.bist1, e.regs.bist1);
        check_value("o_regs.bist2", regs.bist2, e.regs.bist2);
        check_value("o_regs.adc1", regs.adc1, e.regs.adc1);
        check_value("o_regs.adc2", regs.adc2, e.regs.adc2);
        check_value("o_hv_ang_reg_vld", ang_vld, e.ang_vld);
        check_value("o_hv_ang_reg_data", ang_data, e.ang_data);
        check_value("o_hv_dgt_reg_vld", dgt_vld, e.dgt_vld);
    endtask

    // outputs only move on the rising edge, so the falling edge is a quiet point
    task automatic run_cycle(input logic ack, input owt_pkg::owt_cmd_t cmd,
                             input logic [owt_pkg::OWT_DATA_W-1:0] data,
                             input logic status);
        @(negedge clk);
        if (expect_q.size() == 0) begin
            error_count++;
            $display("expected queue ran empty, model lost step with the DUT");
        end else begin
            compare_outputs(expect_q.pop_front());
        end
        rx_ack    = ack;
        rx_cmd    = cmd;
        rx_data   = data;
        rx_status = status;
        apply_model(ack, cmd, data, status);
    endtask

    // mix of mapped, ADC, analog, digital and arbitrary addresses
    function automatic logic [owt_pkg::REG_AW-1:0] random_addr();
        case ($urandom_range(0, 5))
            0: return mapped_addrs[$urandom_range(0, 7)];
            1: return 7'h1F;
            2: return 7'($urandom_range(32'h20, 32'h3F));
            3: return dgt_addrs[$urandom_range(0, 3)];
            default: return 7'($urandom_range(0, 127));
        endcase
    endfunction

    // ========================================
    // stimulus
    // ========================================
    initial begin
        owt_pkg::owt_cmd_t              cmd;
        logic [owt_pkg::OWT_DATA_W-1:0] data;
        logic                           ack;
        logic                           status;

        void'($urandom(12396));
        error_count    = 0;
        check_count    = 0;
        rst_n          = 1'b0;
        rx_ack         = 1'b0;
        rx_cmd         = '0;
        rx_data        = '0;
        rx_status      = 1'b0;
        model_regs     = '0;
        model_ang_data = '0;
        // pipeline starts out holding reset values
        expect_q.push_back('0);
        expect_q.push_back('0);

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // one write to each mapped address
        foreach (mapped_addrs[i]) begin
            cmd.wr   = 1'b1;
            cmd.addr = mapped_addrs[i];
            data     = 20'($urandom_range(0, 32'hFFFFF));
            run_cycle(1'b1, cmd, data, 1'b0);
        end

        // back-to-back random frames, some errored or unstrobed
        repeat (N_RANDOM) begin
            ack      = ($urandom_range(0, 9) != 0);
            status   = ($urandom_range(0, 7) == 0);
            cmd.wr   = 1'($urandom_range(0, 1));
            cmd.addr = random_addr();
            data     = 20'($urandom_range(0, 32'hFFFFF));
            run_cycle(ack, cmd, data, status);
        end

        // flush the last two frames through
        repeat (2) run_cycle(1'b0, '0, '0, 1'b0);

        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- logic/lv_hv_shadow.sv
/*
 * Top level of the low-voltage shadow.
 * The capture stage feeds the shadow bank and the forwarder in parallel;
 * every output follows its input frame by two clock edges.
 */
`timescale 1ns/10ps

module lv_hv_shadow (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    input  logic                             i_owt_rx_ack,
    input  owt_pkg::owt_cmd_t                i_owt_rx_cmd,
    input  logic [owt_pkg::OWT_DATA_W-1:0]   i_owt_rx_data,
    input  logic                             i_owt_rx_status,
    output shadow_pkg::shadow_regs_t         o_regs,
    output logic                             o_hv_ang_reg_vld,
    output logic [owt_pkg::REG_DW-1:0]       o_hv_ang_reg_data,
    output logic                             o_hv_dgt_reg_vld
);

    owt_pkg::owt_frame_t frame;

    // accepted frames only past this point
    owt_frame_capture u_owt_frame_capture (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_owt_rx_ack    (i_owt_rx_ack),
        .i_owt_rx_cmd    (i_owt_rx_cmd),
        .i_owt_rx_data   (i_owt_rx_data),
        .i_owt_rx_status (i_owt_rx_status),
        .o_frame         (frame)
    );

    shadow_reg_bank u_shadow_reg_bank (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_frame (frame),
        .o_regs  (o_regs)
    );

    hv_reg_forward u_hv_reg_forward (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_frame           (frame),
        .o_hv_ang_reg_vld  (o_hv_ang_reg_vld),
        .o_hv_ang_reg_data (o_hv_ang_reg_data),
        .o_hv_dgt_reg_vld  (o_hv_dgt_reg_vld)
    );

endmodule

//--- logic/hv_reg_forward.sv
/*
 * Forwards hits on high-voltage register addresses.
 * Analog range hits give a one-cycle pulse with the low data byte; hits on
 * the digital address list give a one-cycle pulse. Reads and writes alike.
 */
`timescale 1ns/10ps

module hv_reg_forward (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  owt_pkg::owt_frame_t         i_frame,
    output logic                        o_hv_ang_reg_vld,
    output logic [owt_pkg::REG_DW-1:0]  o_hv_ang_reg_data,
    output logic                        o_hv_dgt_reg_vld
);

    logic [owt_pkg::REG_AW-1:0] addr;
    logic                       ang_hit;
    logic                       dgt_hit;
    logic                       ang_fire;
    logic                       dgt_fire;

    assign addr    = i_frame.cmd.addr;
    assign ang_hit = (addr >= shadow_pkg::ANA_START) && (addr <= shadow_pkg::ANA_END);

    // match against the digital list
    always_comb begin
        dgt_hit = 1'b0;
        for (int i = 0; i < shadow_pkg::DGT_NUM; i++) begin
            dgt_hit = dgt_hit | (addr == shadow_pkg::DGT_ADDR_LIST[i]);
        end
    end

    assign ang_fire = i_frame.valid & ang_hit;
    assign dgt_fire = i_frame.valid & dgt_hit;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_hv_ang_reg_vld <= 1'b0;
            o_hv_dgt_reg_vld <= 1'b0;
        end else begin
            o_hv_ang_reg_vld <= ang_fire;
            o_hv_dgt_reg_vld <= dgt_fire;
        end
    end

    // analog byte held until the next analog hit
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_hv_ang_reg_data <= '0;
        end else if (ang_fire) begin
            o_hv_ang_reg_data <= i_frame.data.rv.data;
        end
    end

    // ========================================
    // assertions
    // ========================================
    // analog range and digital list never overlap
    a_pulse_onehot: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !(o_hv_ang_reg_vld && o_hv_dgt_reg_vld)
    );

endmodule

//--- logic/shadow_reg_bank.sv
/*
 * Shadow copies of the high-voltage registers.
 * Write frames are decoded against the shadow map one cycle after capture;
 * the ADC address loads both 10-bit samples from the one data word.
 */
`timescale 1ns/10ps

module shadow_reg_bank (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  owt_pkg::owt_frame_t         i_frame,
    output shadow_pkg::shadow_regs_t    o_regs
);

    shadow_pkg::shadow_regs_t       regs_q;
    owt_pkg::owt_data_u             wdata;
    logic [owt_pkg::REG_AW-1:0]     waddr;
    logic                           wr_en;

    assign wr_en = i_frame.valid & i_frame.cmd.wr;
    assign waddr = i_frame.cmd.addr;
    assign wdata = i_frame.data;

    // ========================================
    // address decode and update
    // ========================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            regs_q <= '0;
        end else if (wr_en) begin
            case (waddr)
                shadow_pkg::ADDR_EFUSE_CFG: begin
                    regs_q.efuse_cfg <= wdata.rv.data;
                end
                shadow_pkg::ADDR_EFUSE_STS: begin
                    regs_q.efuse_sts <= wdata.rv.data;
                end
                shadow_pkg::ADDR_STATUS1: begin
                    regs_q.status1 <= wdata.rv.data;
                end
                shadow_pkg::ADDR_STATUS2: begin
                    regs_q.status2 <= wdata.rv.data;
                end
                shadow_pkg::ADDR_STATUS3: begin
                    regs_q.status3 <= wdata.rv.data;
                end
                shadow_pkg::ADDR_STATUS4: begin
                    regs_q.status4 <= wdata.rv.data;
                end
                shadow_pkg::ADDR_BIST1: begin
                    regs_q.bist1 <= wdata.rv.data;
                end
                shadow_pkg::ADDR_BIST2: begin
                    regs_q.bist2 <= wdata.rv.data;
                end
                // both samples land together
                shadow_pkg::ADDR_ADC: begin
                    regs_q.adc1 <= wdata.adc.adc1;
                    regs_q.adc2 <= wdata.adc.adc2;
                end
                default: begin
                    // unmapped, nothing to shadow
                end
            endcase
        end
    end

    assign o_regs = regs_q;

    // ========================================
    // assertions
    // ========================================
    // reads, idle cycles and dropped frames leave the bank alone
    a_no_stray_update: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !(i_frame.valid && i_frame.cmd.wr) |=> $stable(o_regs)
    );

endmodule

//--- logic/owt_frame_capture.sv
/*
 * Registers one received one-wire frame per cycle.
 * A strobe with the error flag clear becomes a one-cycle valid frame;
 * errored or unstrobed cycles are dropped here and nowhere else.
 */
`timescale 1ns/10ps

module owt_frame_capture (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    input  logic                             i_owt_rx_ack,
    input  owt_pkg::owt_cmd_t                i_owt_rx_cmd,
    input  logic [owt_pkg::OWT_DATA_W-1:0]   i_owt_rx_data,
    input  logic                             i_owt_rx_status,
    output owt_pkg::owt_frame_t              o_frame
);

    logic                accept;
    logic                frame_vld;
    owt_pkg::owt_cmd_t   cmd_q;
    owt_pkg::owt_data_u  data_q;

    // status high means the link saw an error
    assign accept = i_owt_rx_ack & ~i_owt_rx_status;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            frame_vld <= 1'b0;
        end else begin
            frame_vld <= accept;
        end
    end

    // payload held between accepted frames
    always_ff @(posedge i_clk) begin
        if (accept) begin
            cmd_q  <= i_owt_rx_cmd;
            data_q <= i_owt_rx_data;
        end
    end

    assign o_frame.valid = frame_vld;
    assign o_frame.cmd   = cmd_q;
    assign o_frame.data  = data_q;

    // ========================================
    // assertions
    // ========================================
    // an errored strobe never produces a frame
    a_err_dropped: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_owt_rx_ack && i_owt_rx_status) |=> !o_frame.valid
    );

endmodule

//--- logic/shadow_pkg.sv
/*
 * Low-voltage shadow register map.
 * Holds the mapped shadow addresses, the analog forward range, the list of
 * digital addresses that raise a hit and the struct of shadow outputs.
 */
package shadow_pkg;

    // ========================================
    // shadow register addresses
    // ========================================
    localparam logic [owt_pkg::REG_AW-1:0] ADDR_EFUSE_CFG = 7'h06;
    localparam logic [owt_pkg::REG_AW-1:0] ADDR_EFUSE_STS = 7'h07;
    localparam logic [owt_pkg::REG_AW-1:0] ADDR_STATUS1   = 7'h08;
    localparam logic [owt_pkg::REG_AW-1:0] ADDR_STATUS2   = 7'h0A;
    localparam logic [owt_pkg::REG_AW-1:0] ADDR_STATUS3   = 7'h0C;
    localparam logic [owt_pkg::REG_AW-1:0] ADDR_STATUS4   = 7'h0D;
    localparam logic [owt_pkg::REG_AW-1:0] ADDR_BIST1     = 7'h14;
    localparam logic [owt_pkg::REG_AW-1:0] ADDR_BIST2     = 7'h15;
    // both ADC samples share this one
    localparam logic [owt_pkg::REG_AW-1:0] ADDR_ADC       = 7'h1F;

    // ========================================
    // forwarded ranges
    // ========================================
    // analog range, inclusive both ends
    localparam logic [owt_pkg::REG_AW-1:0] ANA_START = 7'h20;
    localparam logic [owt_pkg::REG_AW-1:0] ANA_END   = 7'h3F;

    localparam int unsigned DGT_NUM = 4;

    // entry 0 is the lowest address
    localparam logic [DGT_NUM-1:0][owt_pkg::REG_AW-1:0] DGT_ADDR_LIST = {
        7'h50,
        7'h48,
        7'h41,
        7'h40
    };

    // ========================================
    // shadow outputs
    // ========================================
    // efuse registers kept as plain bytes
    typedef struct packed {
        logic [owt_pkg::REG_DW-1:0] efuse_cfg;
        logic [owt_pkg::REG_DW-1:0] efuse_sts;
        logic [owt_pkg::REG_DW-1:0] status1;
        logic [owt_pkg::REG_DW-1:0] status2;
        logic [owt_pkg::REG_DW-1:0] status3;
        logic [owt_pkg::REG_DW-1:0] status4;
        logic [owt_pkg::REG_DW-1:0] bist1;
        logic [owt_pkg::REG_DW-1:0] bist2;
        logic [owt_pkg::ADC_DW-1:0] adc1;
        logic [owt_pkg::ADC_DW-1:0] adc2;
    } shadow_regs_t;

endpackage

//--- logic/owt_pkg.sv
/*
 * One-wire link definitions shared by the capture stage and the consumers.
 * Covers frame widths, the command layout, the two readings of the data word
 * and the captured frame passed between modules.
 */
package owt_pkg;

    // ========================================
    // link widths
    // ========================================
    localparam int unsigned OWT_CMD_W  = 8;
    localparam int unsigned OWT_DATA_W = 20;
    // command is write flag over the address
    localparam int unsigned REG_AW     = OWT_CMD_W - 1;
    localparam int unsigned REG_DW     = 8;
    localparam int unsigned ADC_DW     = 10;

    // ========================================
    // frame types
    // ========================================
    typedef struct packed {
        logic              wr;
        logic [REG_AW-1:0] addr;
    } owt_cmd_t;

    // byte registers use only the low byte
    typedef struct packed {
        logic [OWT_DATA_W-REG_DW-1:0] pad;
        logic [REG_DW-1:0]            data;
    } owt_reg_view_t;

    // dual sample word at the ADC address
    typedef struct packed {
        logic [ADC_DW-1:0] adc2;
        logic [ADC_DW-1:0] adc1;
    } owt_adc_view_t;

    typedef union packed {
        owt_reg_view_t rv;
        owt_adc_view_t adc;
    } owt_data_u;

    // 29 bits, one accepted frame
    typedef struct packed {
        logic      valid;
        owt_cmd_t  cmd;
        owt_data_u data;
    } owt_frame_t;

endpackage
